//--- uart_pkg.sv
`default_nettype none

package uart_pkg;

	localparam int BIT_PERIOD_W = 12;
	localparam int DATA_BITS = 8;

	// bit length minus one, in PCLK cycles
	typedef logic [BIT_PERIOD_W-1:0] bit_period_t;
	typedef logic [DATA_BITS-1:0] uart_byte_t;
	typedef logic [3:0] bit_index_t;

	typedef enum logic [2:0]
	{
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_PARITY,
		RX_STOP
	} rx_state_t;

	typedef enum logic [2:0]
	{
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_PARITY,
		TX_STOP
	} tx_state_t;

	// one received frame, as reported with rx_valid
	typedef struct packed
	{
		uart_byte_t data;
		logic parity;
		logic parity_err;
		logic stop_err;
	} rx_frame_t;

endpackage

`default_nettype wire

//--- uart_bit_timer.sv
`timescale 1ns/10ps
`default_nettype none

module uart_bit_timer
(
	input logic PCLK,
	input logic RESET,
	input logic run,
	input uart_pkg::bit_period_t bit_period,
	output logic mid,
	output logic last
);

	uart_pkg::bit_period_t count;
	uart_pkg::bit_period_t half;

	assign half = bit_period >> 1;

	// held at zero while stopped, wraps after the full period
	always_ff @(posedge PCLK)
	begin
		if (RESET)
		begin
			count <= '0;
		end
		else if (!run)
		begin
			count <= '0;
		end
		else if (count == bit_period)
		begin
			count <= '0;
		end
		else
		begin
			count <= count + uart_pkg::bit_period_t'(1);
		end
	end

	assign mid = run && (count == half);
	assign last = run && (count == bit_period);

endmodule

`default_nettype wire

//--- uart_rx_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module uart_rx_ctrl
(
	input logic PCLK,
	input logic RESET,
	input logic rx,
	input logic mid,
	input logic last,
	output logic run,
	output logic line,
	output logic take_data,
	output logic take_parity,
	output logic take_stop
);

	logic [1:0] sync_q;
	uart_pkg::rx_state_t state;
	uart_pkg::rx_state_t state_next;
	uart_pkg::bit_index_t bit_cnt;
	logic data_done;

	// two-flop synchronizer, idles high like the line
	always_ff @(posedge PCLK)
	begin
		if (RESET)
		begin
			sync_q <= 2'b11;
		end
		else
		begin
			sync_q <= {sync_q[0], rx};
		end
	end

	assign line = sync_q[1];

	assign data_done = (bit_cnt == uart_pkg::bit_index_t'(uart_pkg::DATA_BITS));

	always_comb
	begin
		state_next = state;
		case (state)
			uart_pkg::RX_IDLE:
			begin
				if (!line)
				begin
					state_next = uart_pkg::RX_START;
				end
			end
			uart_pkg::RX_START:
			begin
				// false start when the line is back high at mid-bit
				if (mid)
				begin
					state_next = line ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
				end
			end
			uart_pkg::RX_DATA:
			begin
				if (last && data_done)
				begin
					state_next = uart_pkg::RX_PARITY;
				end
			end
			uart_pkg::RX_PARITY:
			begin
				if (last)
				begin
					state_next = uart_pkg::RX_STOP;
				end
			end
			uart_pkg::RX_STOP:
			begin
				// leave at mid-stop so a following start edge is not missed
				if (mid)
				begin
					state_next = uart_pkg::RX_IDLE;
				end
			end
			default:
			begin
				state_next = uart_pkg::RX_IDLE;
			end
		endcase
	end

	always_ff @(posedge PCLK)
	begin
		if (RESET)
		begin
			state <= uart_pkg::RX_IDLE;
			bit_cnt <= '0;
		end
		else
		begin
			state <= state_next;
			if (state != uart_pkg::RX_DATA)
			begin
				bit_cnt <= '0;
			end
			else if (mid)
			begin
				bit_cnt <= bit_cnt + uart_pkg::bit_index_t'(1);
			end
		end
	end

	assign run = (state != uart_pkg::RX_IDLE);
	assign take_data = (state == uart_pkg::RX_DATA) && mid;
	assign take_parity = (state == uart_pkg::RX_PARITY) && mid;
	assign take_stop = (state == uart_pkg::RX_STOP) && mid;

endmodule

`default_nettype wire

//--- uart_rx_shift.sv
`timescale 1ns/10ps
`default_nettype none

module uart_rx_shift
(
	input logic PCLK,
	input logic RESET,
	input logic line,
	input logic take_data,
	input logic take_parity,
	input logic take_stop,
	output logic rx_valid,
	output uart_pkg::rx_frame_t rx_frame
);

	uart_pkg::uart_byte_t shreg;
	logic parity_q;

	// lsb arrives first and ends up in bit 0
	always_ff @(posedge PCLK)
	begin
		if (take_data)
		begin
			shreg <= {line, shreg[uart_pkg::DATA_BITS-1:1]};
		end
		if (take_parity)
		begin
			parity_q <= line;
		end
	end

	always_ff @(posedge PCLK)
	begin
		if (RESET)
		begin
			rx_valid <= 1'b0;
			rx_frame <= '0;
		end
		else
		begin
			rx_valid <= take_stop;
			if (take_stop)
			begin
				rx_frame.data <= shreg;
				rx_frame.parity <= parity_q;
				// even parity over data and parity bit
				rx_frame.parity_err <= ^{shreg, parity_q};
				rx_frame.stop_err <= !line;
			end
		end
	end

endmodule

`default_nettype wire

//--- uart_tx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_tx
(
	input logic PCLK,
	input logic RESET,
	input uart_pkg::bit_period_t bit_period,
	input logic tx_start,
	input uart_pkg::uart_byte_t tx_data,
	output logic tx,
	output logic tx_busy,
	output logic tx_done
);

	uart_pkg::tx_state_t state;
	uart_pkg::uart_byte_t shreg;
	uart_pkg::bit_index_t bit_cnt;
	logic parity_q;
	logic accept;
	logic last;

	uart_bit_timer uart_bit_timer_inst
	(
		.PCLK(PCLK),
		.RESET(RESET),
		.run(tx_busy),
		.bit_period(bit_period),
		.mid(),
		.last(last)
	);

	// requests while busy are dropped
	assign accept = (state == uart_pkg::TX_IDLE) && tx_start;

	always_ff @(posedge PCLK)
	begin
		if (accept)
		begin
			shreg <= tx_data;
			parity_q <= ^tx_data;
		end
		else if ((state == uart_pkg::TX_DATA) && last)
		begin
			shreg <= shreg >> 1;
		end
	end

	always_ff @(posedge PCLK)
	begin
		if (RESET)
		begin
			state <= uart_pkg::TX_IDLE;
			bit_cnt <= '0;
			tx <= 1'b1;
		end
		else
		begin
			case (state)
				uart_pkg::TX_IDLE:
				begin
					bit_cnt <= '0;
					if (accept)
					begin
						state <= uart_pkg::TX_START;
						tx <= 1'b0;
					end
				end
				uart_pkg::TX_START:
				begin
					if (last)
					begin
						state <= uart_pkg::TX_DATA;
						tx <= shreg[0];
					end
				end
				uart_pkg::TX_DATA:
				begin
					if (last)
					begin
						bit_cnt <= bit_cnt + uart_pkg::bit_index_t'(1);
						if (bit_cnt == uart_pkg::bit_index_t'(uart_pkg::DATA_BITS - 1))
						begin
							state <= uart_pkg::TX_PARITY;
							tx <= parity_q;
						end
						else
						begin
							// next bit, shreg shifts in the same cycle
							tx <= shreg[1];
						end
					end
				end
				uart_pkg::TX_PARITY:
				begin
					if (last)
					begin
						state <= uart_pkg::TX_STOP;
						tx <= 1'b1;
					end
				end
				uart_pkg::TX_STOP:
				begin
					if (last)
					begin
						state <= uart_pkg::TX_IDLE;
					end
				end
				default:
				begin
					state <= uart_pkg::TX_IDLE;
					tx <= 1'b1;
				end
			endcase
		end
	end

	assign tx_busy = (state != uart_pkg::TX_IDLE);
	assign tx_done = (state == uart_pkg::TX_STOP) && last;

endmodule

`default_nettype wire

//--- uart_core.sv
`timescale 1ns/10ps
`default_nettype none

module uart_core
(
	input logic PCLK,
	input logic RESET,
	input logic rx,
	input uart_pkg::bit_period_t bit_period,
	input logic tx_start,
	input uart_pkg::uart_byte_t tx_data,
	output logic tx,
	output logic tx_busy,
	output logic tx_done,
	output logic rx_valid,
	output uart_pkg::rx_frame_t rx_frame
);

	logic rx_run;
	logic rx_mid;
	logic rx_last;
	logic rx_line;
	logic take_data;
	logic take_parity;
	logic take_stop;

	uart_rx_ctrl uart_rx_ctrl_inst
	(
		.PCLK(PCLK),
		.RESET(RESET),
		.rx(rx),
		.mid(rx_mid),
		.last(rx_last),
		.run(rx_run),
		.line(rx_line),
		.take_data(take_data),
		.take_parity(take_parity),
		.take_stop(take_stop)
	);

	// receive bit timer
	uart_bit_timer uart_bit_timer_rx_inst
	(
		.PCLK(PCLK),
		.RESET(RESET),
		.run(rx_run),
		.bit_period(bit_period),
		.mid(rx_mid),
		.last(rx_last)
	);

	uart_rx_shift uart_rx_shift_inst
	(
		.PCLK(PCLK),
		.RESET(RESET),
		.line(rx_line),
		.take_data(take_data),
		.take_parity(take_parity),
		.take_stop(take_stop),
		.rx_valid(rx_valid),
		.rx_frame(rx_frame)
	);

	uart_tx uart_tx_inst
	(
		.PCLK(PCLK),
		.RESET(RESET),
		.bit_period(bit_period),
		.tx_start(tx_start),
		.tx_data(tx_data),
		.tx(tx),
		.tx_busy(tx_busy),
		.tx_done(tx_done)
	);

endmodule

`default_nettype wire

//--- uart_props.sv
`timescale 1ns/10ps
`default_nettype none

module uart_props
(
	input logic PCLK,
	input logic RESET,
	input logic tx,
	input logic tx_busy,
	input logic tx_done,
	input logic rx_valid,
	input uart_pkg::rx_frame_t rx_frame
);

	int assert_fails = 0;

	rx_valid_single: assert property (@(posedge PCLK) disable iff (RESET)
		rx_valid |=> !rx_valid)
		else
		begin
			assert_fails++;
			$error("rx_valid held for more than one cycle");
		end

	// line idles high between frames
	tx_idle_high: assert property (@(posedge PCLK) disable iff (RESET)
		!tx_busy |-> tx)
		else
		begin
			assert_fails++;
			$error("tx low while transmitter idle");
		end

	tx_done_ends_busy: assert property (@(posedge PCLK) disable iff (RESET)
		tx_done |=> !tx_busy)
		else
		begin
			assert_fails++;
			$error("tx_busy still high after tx_done");
		end

	outputs_known: assert property (@(posedge PCLK) disable iff (RESET)
		!$isunknown({tx, tx_busy, tx_done, rx_valid, rx_frame}))
		else
		begin
			assert_fails++;
			$error("unknown value on a DUT output");
		end

endmodule

`default_nettype wire

//--- uart_checker.sv
`timescale 1ns/10ps
`default_nettype none

module uart_checker
(
	input logic PCLK,
	input logic RESET,
	input uart_pkg::bit_period_t bit_period,
	input logic tx,
	input logic tx_done,
	input logic rx_valid,
	input uart_pkg::rx_frame_t rx_frame,
	output int fail_count
);

	uart_pkg::rx_frame_t rx_expected[$];
	uart_pkg::rx_frame_t tx_expected[$];
	uart_pkg::rx_frame_t rx_want;
	string test_name;
	int test_checks;
	int test_fails;
	int total_checks;
	logic tx_prev;

	initial
	begin
		fail_count = 0;
		total_checks = 0;
		test_checks = 0;
		test_fails = 0;
		test_name = "none";
	end

	task automatic begin_test(input string name);
		test_name = name;
		test_checks = 0;
		test_fails = 0;
	endtask

	task automatic queue_rx_frame(input uart_pkg::rx_frame_t frame);
		rx_expected.push_back(frame);
	endtask

	task automatic queue_tx_frame(input uart_pkg::rx_frame_t frame);
		tx_expected.push_back(frame);
	endtask

	task automatic note_failure(input string msg);
		$display("test %s: %s", test_name, msg);
		test_fails++;
		fail_count++;
	endtask

	task automatic check_frame(input string what, input uart_pkg::rx_frame_t want,
		input uart_pkg::rx_frame_t got);
		test_checks++;
		total_checks++;
		if (got !== want)
		begin
			$display("MISMATCH %s %s: expected %03h actual %03h", test_name, what, want, got);
			test_fails++;
			fail_count++;
		end
	endtask

	task automatic end_test();
		if (rx_expected.size() != 0)
		begin
			note_failure($sformatf("%0d expected rx frames never arrived", rx_expected.size()));
			rx_expected.delete();
		end
		if (tx_expected.size() != 0)
		begin
			note_failure($sformatf("%0d requested bytes never appeared on tx", tx_expected.size()));
			tx_expected.delete();
		end
		$display("test %s: %0d checks, %0d failed", test_name, test_checks, test_fails);
	endtask

	task automatic report_totals(input int assert_fails);
		$display("summary: %0d checks, %0d failed, %0d assertion failures",
			total_checks, fail_count, assert_fails);
	endtask

	// rebuild one frame from tx, sampled at each mid-bit
	task automatic capture_tx_frame();
		logic [10:0] bits;
		uart_pkg::rx_frame_t got;
		int i;
		repeat (int'(bit_period) / 2) @(negedge PCLK);
		bits[0] = tx;
		for (i = 1; i < 11; i++)
		begin
			repeat (int'(bit_period) + 1) @(negedge PCLK);
			bits[i] = tx;
		end
		got.data = bits[8:1];
		got.parity = bits[9];
		got.parity_err = ^bits[9:1];
		got.stop_err = !bits[10];
		if (bits[0])
		begin
			note_failure("start bit on tx was high at mid-bit");
		end
		else if (tx_expected.size() == 0)
		begin
			note_failure("tx sent a frame that was never requested");
		end
		else
		begin
			check_frame("tx frame", tx_expected.pop_front(), got);
		end
		// tx_done belongs to the last cycle of the stop bit
		repeat (int'(bit_period) - int'(bit_period) / 2) @(negedge PCLK);
		if (tx_done !== 1'b1)
		begin
			note_failure("tx_done did not pulse in the last cycle of the stop bit");
		end
	endtask

	always @(negedge PCLK)
	begin
		if (!RESET && rx_valid)
		begin
			if (rx_expected.size() == 0)
			begin
				note_failure("rx_valid pulsed with no frame expected");
			end
			else
			begin
				rx_want = rx_expected.pop_front();
				check_frame("rx frame", rx_want, rx_frame);
			end
		end
	end

	initial
	begin
		tx_prev = 1'b1;
		forever
		begin
			@(negedge PCLK);
			if (!RESET && tx_prev && !tx)
			begin
				capture_tx_frame();
			end
			tx_prev = tx;
		end
	end

endmodule

`default_nettype wire

//--- uart_tb.sv
`timescale 1ns/10ps
`default_nettype none

module uart_tb;

	localparam uart_pkg::bit_period_t DIRECT_PERIOD = 12'd15;
	localparam uart_pkg::bit_period_t LOOP_PERIOD = 12'd23;
	localparam int FRAME_COUNT = 34;
	localparam int MARGIN_CYCLES = 4000;
	localparam int TIMEOUT_CYCLES = FRAME_COUNT * 11 * (int'(LOOP_PERIOD) + 1) + MARGIN_CYCLES;

	logic PCLK;
	logic RESET;
	logic rx;
	logic drv_rx;
	logic loopback;
	uart_pkg::bit_period_t bit_period;
	logic tx_start;
	uart_pkg::uart_byte_t tx_data;
	logic tx;
	logic tx_busy;
	logic tx_done;
	logic rx_valid;
	uart_pkg::rx_frame_t rx_frame;
	logic [31:0] lfsr;
	int fail_count;
	int cycle_count;
	int i;
	uart_pkg::uart_byte_t b;

	// serial input comes from the driver or from our own tx
	assign rx = loopback ? tx : drv_rx;

	uart_core uart_core_inst
	(
		.PCLK(PCLK),
		.RESET(RESET),
		.rx(rx),
		.bit_period(bit_period),
		.tx_start(tx_start),
		.tx_data(tx_data),
		.tx(tx),
		.tx_busy(tx_busy),
		.tx_done(tx_done),
		.rx_valid(rx_valid),
		.rx_frame(rx_frame)
	);

	uart_checker uart_checker_inst
	(
		.PCLK(PCLK),
		.RESET(RESET),
		.bit_period(bit_period),
		.tx(tx),
		.tx_done(tx_done),
		.rx_valid(rx_valid),
		.rx_frame(rx_frame),
		.fail_count(fail_count)
	);

	bind uart_core uart_props uart_props_inst
	(
		.PCLK(PCLK),
		.RESET(RESET),
		.tx(tx),
		.tx_busy(tx_busy),
		.tx_done(tx_done),
		.rx_valid(rx_valid),
		.rx_frame(rx_frame)
	);

	initial
	begin
		PCLK = 1'b0;
		forever #2 PCLK = ~PCLK;
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_byte(output uart_pkg::uart_byte_t value);
		int k;
		for (k = 0; k < 8; k++)
		begin
			lfsr = lfsr_step(lfsr);
			value[k] = lfsr[0];
		end
	endtask

	// even parity, flip_parity sends the wrong parity bit
	function automatic uart_pkg::rx_frame_t expected_frame(input uart_pkg::uart_byte_t data,
		input logic flip_parity, input logic stop_bit);
		uart_pkg::rx_frame_t f;
		f.data = data;
		f.parity = (^data) ^ flip_parity;
		f.parity_err = flip_parity;
		f.stop_err = !stop_bit;
		return f;
	endfunction

	task automatic idle_bits(input int n);
		repeat (n * (int'(bit_period) + 1)) @(posedge PCLK);
	endtask

	task automatic send_frame(input uart_pkg::uart_byte_t data, input logic parity_bit,
		input logic stop_bit);
		logic [10:0] bits;
		int k;
		bits = {stop_bit, parity_bit, data, 1'b0};
		for (k = 0; k < 11; k++)
		begin
			drv_rx <= bits[k];
			repeat (int'(bit_period) + 1) @(posedge PCLK);
		end
		drv_rx <= 1'b1;
	endtask

	task automatic send_checked_frame(input uart_pkg::uart_byte_t data, input logic flip_parity,
		input logic stop_bit);
		uart_pkg::rx_frame_t f;
		f = expected_frame(data, flip_parity, stop_bit);
		uart_checker_inst.queue_rx_frame(f);
		send_frame(f.data, f.parity, stop_bit);
		idle_bits(1);
	endtask

	task automatic start_tx(input uart_pkg::uart_byte_t data);
		uart_checker_inst.queue_tx_frame(expected_frame(data, 1'b0, 1'b1));
		tx_start <= 1'b1;
		tx_data <= data;
		@(posedge PCLK);
		tx_start <= 1'b0;
	endtask

	task automatic wait_tx_done();
		do
		begin
			@(negedge PCLK);
		end
		while (!tx_done);
		@(posedge PCLK);
	endtask

	initial
	begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge PCLK);
			cycle_count++;
		end
		$display("timeout: test sequence still running after %0d cycles", TIMEOUT_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		RESET <= 1'b1;
		drv_rx <= 1'b1;
		loopback <= 1'b0;
		bit_period <= DIRECT_PERIOD;
		tx_start <= 1'b0;
		tx_data <= '0;
		lfsr = 32'h60d9;
		repeat (16) @(posedge PCLK);
		RESET <= 1'b0;
		idle_bits(1);

		uart_checker_inst.begin_test("rx_random");
		for (i = 0; i < 16; i++)
		begin
			random_byte(b);
			send_checked_frame(b, 1'b0, 1'b1);
		end
		uart_checker_inst.end_test();

		uart_checker_inst.begin_test("rx_parity_error");
		for (i = 0; i < 4; i++)
		begin
			random_byte(b);
			send_checked_frame(b, 1'b1, 1'b1);
		end
		uart_checker_inst.end_test();

		uart_checker_inst.begin_test("rx_stop_error");
		random_byte(b);
		send_checked_frame(b, 1'b0, 1'b0);
		uart_checker_inst.end_test();

		// glitch of a quarter bit, gone before mid-bit
		// idle for longer than a whole frame so a wrongly taken start shows up alone
		uart_checker_inst.begin_test("rx_false_start");
		drv_rx <= 1'b0;
		repeat ((int'(bit_period) + 1) / 4) @(posedge PCLK);
		drv_rx <= 1'b1;
		idle_bits(12);
		random_byte(b);
		send_checked_frame(b, 1'b0, 1'b1);
		uart_checker_inst.end_test();

		uart_checker_inst.begin_test("tx_random");
		for (i = 0; i < 8; i++)
		begin
			random_byte(b);
			start_tx(b);
			if (i == 3)
			begin
				// request while busy, must not make a frame
				idle_bits(3);
				random_byte(b);
				tx_start <= 1'b1;
				tx_data <= b;
				@(posedge PCLK);
				tx_start <= 1'b0;
			end
			wait_tx_done();
			idle_bits(1);
		end
		uart_checker_inst.end_test();

		uart_checker_inst.begin_test("loopback");
		bit_period <= LOOP_PERIOD;
		loopback <= 1'b1;
		@(posedge PCLK);
		for (i = 0; i < 4; i++)
		begin
			random_byte(b);
			uart_checker_inst.queue_rx_frame(expected_frame(b, 1'b0, 1'b1));
			start_tx(b);
			wait_tx_done();
			idle_bits(1);
		end
		uart_checker_inst.end_test();

		uart_checker_inst.report_totals(uart_core_inst.uart_props_inst.assert_fails);
		if (fail_count == 0 && uart_core_inst.uart_props_inst.assert_fails == 0)
		begin
			$display("ALL TESTS PASSED");
		end
		else
		begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
uart_pkg.sv
uart_bit_timer.sv
uart_rx_ctrl.sv
uart_rx_shift.sv
uart_tx.sv
uart_core.sv
uart_props.sv
uart_checker.sv
uart_tb.sv
